// File: common/ooo_core_pkg.sv
package ooo_core_pkg;

  // One reservation station entry
  typedef struct packed {
    logic                                busy;        // Entry holds an instruction
    ooo_isa_pkg::op_e                    op;          // Operation to perform
    logic [ooo_isa_pkg::tag_width-1:0]   dest_tag;    // Result tag
    logic [ooo_isa_pkg::tag_width-1:0]   src1_tag;    // First operand tag
    logic                                src1_ready;  // First operand available
    logic [ooo_isa_pkg::tag_width-1:0]   src2_tag;    // Second operand tag
    logic                                src2_ready;  // Second operand available
  } rs_entry_t;

  // Cleared entry
  localparam rs_entry_t rs_entry_reset = '{
    busy:       1'b0,
    op:         ooo_isa_pkg::OP_ADD,
    dest_tag:   '0,
    src1_tag:   '0,
    src1_ready: 1'b0,
    src2_tag:   '0,
    src2_ready: 1'b0
  };

  // Entries below num_alu feed ALUs, the last one feeds the multiplier
  function automatic ooo_isa_pkg::fu_kind_e entry_kind(input int idx, input int num_alu);
    ooo_isa_pkg::fu_kind_e kind;
    if (idx < num_alu) begin
      kind = ooo_isa_pkg::FU_ALU;
    end else begin
      kind = ooo_isa_pkg::FU_MULT;
    end
    return kind;
  endfunction

endpackage

// File: common/ooo_isa_pkg.sv
package ooo_isa_pkg;

  localparam int value_width = 16;  // Data value width
  localparam int tag_width   = 5;   // 32 tags

  // Unit class an instruction needs
  typedef enum logic [0:0] {
    FU_ALU  = 1'b0,
    FU_MULT = 1'b1
  } fu_kind_e;

  // Operation codes
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_MUL = 3'd5
  } op_e;

endpackage

// File: logic/alu_unit.sv
`timescale 1ns/1ps

module alu_unit (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                issue_valid,
  input  ooo_isa_pkg::op_e                    issue_op,
  input  logic [ooo_isa_pkg::tag_width-1:0]   issue_dest,
  input  logic [ooo_isa_pkg::value_width-1:0] src1_value,
  input  logic [ooo_isa_pkg::value_width-1:0] src2_value,
  input  logic                                grant,
  output logic                                req,
  output logic [ooo_isa_pkg::tag_width-1:0]   res_tag,
  output logic [ooo_isa_pkg::value_width-1:0] res_value,
  output logic                                busy
);

  logic [ooo_isa_pkg::value_width-1:0] alu_out;  // Combinational result

  always_comb begin
    case (issue_op)
      ooo_isa_pkg::OP_ADD: alu_out = src1_value + src2_value;
      ooo_isa_pkg::OP_SUB: alu_out = src1_value - src2_value;
      ooo_isa_pkg::OP_AND: alu_out = src1_value & src2_value;
      ooo_isa_pkg::OP_OR:  alu_out = src1_value | src2_value;
      ooo_isa_pkg::OP_XOR: alu_out = src1_value ^ src2_value;
      default:             alu_out = '0;  // Multiply never lands here
    endcase
  end

  // Request flag, held until the CDB takes it
  always_ff @(posedge clock) begin
    if (reset) begin
      req <= 1'b0;
    end else if (issue_valid) begin
      req <= 1'b1;  // New result, may replace one granted this cycle
    end else if (grant) begin
      req <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_valid) begin
      res_tag   <= issue_dest;
      res_value <= alu_out;
    end
  end

  assign busy = req && !grant;  // Result stuck for another cycle

endmodule

// File: logic/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter #(
  parameter int NUM_REQ = 3
) (
  input  logic                                                clock,
  input  logic                                                reset,
  input  logic [NUM_REQ-1:0]                                  req,
  input  logic [NUM_REQ-1:0][ooo_isa_pkg::tag_width-1:0]      res_tag,
  input  logic [NUM_REQ-1:0][ooo_isa_pkg::value_width-1:0]    res_value,
  output logic [NUM_REQ-1:0]                                  grant,
  output logic                                                cdb_valid,
  output logic [ooo_isa_pkg::tag_width-1:0]                   cdb_tag,
  output logic [ooo_isa_pkg::value_width-1:0]                 cdb_value
);

  localparam int PTR_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

  logic [PTR_W-1:0] ptr;     // First requester to look at
  logic             found;   // Someone requested
  int               winner;  // Granted index
  int               idx;     // Scan position

  // Scan from the pointer, wrap around
  always_comb begin
    grant  = '0;
    found  = 1'b0;
    winner = 0;
    idx    = 0;
    for (int k = 0; k < NUM_REQ; k++) begin
      idx = (int'(ptr) + k) % NUM_REQ;
      if (!found && req[idx]) begin
        found  = 1'b1;
        winner = idx;
      end
    end
    if (found) begin
      grant[winner] = 1'b1;
    end
  end

  assign cdb_valid = found;
  assign cdb_tag   = res_tag[winner];    // Winner onto the bus
  assign cdb_value = res_value[winner];

  always_ff @(posedge clock) begin
    if (reset) begin
      ptr <= '0;
    end else if (found) begin
      if (winner == NUM_REQ - 1) begin
        ptr <= '0;
      end else begin
        ptr <= PTR_W'(winner + 1);  // Just past the winner
      end
    end
  end

endmodule

// File: logic/mult_unit.sv
`timescale 1ns/1ps

module mult_unit #(
  parameter int MULT_STAGES = 3
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                issue_valid,
  input  ooo_isa_pkg::op_e                    issue_op,
  input  logic [ooo_isa_pkg::tag_width-1:0]   issue_dest,
  input  logic [ooo_isa_pkg::value_width-1:0] src1_value,
  input  logic [ooo_isa_pkg::value_width-1:0] src2_value,
  input  logic                                grant,
  output logic                                req,
  output logic [ooo_isa_pkg::tag_width-1:0]   res_tag,
  output logic [ooo_isa_pkg::value_width-1:0] res_value,
  output logic                                busy
);

  logic [MULT_STAGES-1:0]                                  stage_valid;  // Occupied stages
  logic [MULT_STAGES-1:0][ooo_isa_pkg::tag_width-1:0]     stage_tag;    // Tag per stage
  logic [MULT_STAGES-1:0][ooo_isa_pkg::value_width-1:0]   stage_prod;   // Product per stage
  logic [2*ooo_isa_pkg::value_width-1:0]                  full_prod;    // Wide product
  logic [ooo_isa_pkg::value_width-1:0]                    first_prod;   // Stage 0 input
  logic                                                   advance;      // Chain moves

  assign full_prod  = src1_value * src2_value;
  assign first_prod = (issue_op == ooo_isa_pkg::OP_MUL) ?
                      full_prod[ooo_isa_pkg::value_width-1:0] : '0;  // Low half only

  assign advance = !(stage_valid[MULT_STAGES-1] && !grant);  // Stall on blocked tail

  always_ff @(posedge clock) begin
    if (reset) begin
      stage_valid <= '0;
    end else if (advance) begin
      stage_valid[0] <= issue_valid;
      for (int k = 1; k < MULT_STAGES; k++) begin
        stage_valid[k] <= stage_valid[k-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      stage_tag[0]  <= issue_dest;
      stage_prod[0] <= first_prod;
      for (int k = 1; k < MULT_STAGES; k++) begin
        stage_tag[k]  <= stage_tag[k-1];
        stage_prod[k] <= stage_prod[k-1];
      end
    end
  end

  assign req       = stage_valid[MULT_STAGES-1];  // Tail holds a finished product
  assign res_tag   = stage_tag[MULT_STAGES-1];
  assign res_value = stage_prod[MULT_STAGES-1];
  assign busy      = !advance;                     // Only a blocked tail stops issue

endmodule

// File: logic/ooo_exec_core.sv
`timescale 1ns/1ps

module ooo_exec_core #(
  parameter int NUM_ALU     = 2,
  parameter int MULT_STAGES = 3
) (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                en,
  input  logic                                dispatch_en,
  input  ooo_isa_pkg::fu_kind_e               dispatch_kind,
  input  ooo_isa_pkg::op_e                    dispatch_op,
  input  logic [ooo_isa_pkg::tag_width-1:0]   dest_tag,
  input  logic [ooo_isa_pkg::tag_width-1:0]   src1_tag,
  input  logic                                src1_ready,
  input  logic [ooo_isa_pkg::tag_width-1:0]   src2_tag,
  input  logic                                src2_ready,
  input  logic                                preload_en,
  input  logic [ooo_isa_pkg::tag_width-1:0]   preload_tag,
  input  logic [ooo_isa_pkg::value_width-1:0] preload_value,
  output logic                                rs_hazard,
  output logic                                cdb_valid,
  output logic [ooo_isa_pkg::tag_width-1:0]   cdb_tag,
  output logic [ooo_isa_pkg::value_width-1:0] cdb_value
);

  localparam int NUM_REQ = NUM_ALU + 1;  // ALUs plus the multiplier
  localparam int NUM_RD  = 2 * NUM_REQ;  // Two read ports per unit

  logic [NUM_REQ-1:0]                                  issue_valid;
  ooo_isa_pkg::op_e [NUM_REQ-1:0]                      issue_op;
  logic [NUM_REQ-1:0][ooo_isa_pkg::tag_width-1:0]      issue_dest;
  logic [NUM_REQ-1:0][ooo_isa_pkg::tag_width-1:0]      issue_src1;
  logic [NUM_REQ-1:0][ooo_isa_pkg::tag_width-1:0]      issue_src2;
  logic [NUM_REQ-1:0]                                  unit_busy;
  logic [NUM_REQ-1:0]                                  req;
  logic [NUM_REQ-1:0]                                  grant;
  logic [NUM_REQ-1:0][ooo_isa_pkg::tag_width-1:0]      res_tag;
  logic [NUM_REQ-1:0][ooo_isa_pkg::value_width-1:0]    res_value;
  logic [NUM_RD-1:0][ooo_isa_pkg::tag_width-1:0]       rd_tag;
  logic [NUM_RD-1:0][ooo_isa_pkg::value_width-1:0]     rd_value;

  reservation_station #(.NUM_ALU(NUM_ALU)) u_rs (
    .clock, .reset, .en, .dispatch_en, .dispatch_kind, .dispatch_op,
    .dest_tag, .src1_tag, .src1_ready, .src2_tag, .src2_ready,
    .cdb_valid, .cdb_tag, .unit_busy, .rs_hazard,
    .issue_valid, .issue_op, .issue_dest, .issue_src1, .issue_src2
  );

  for (genvar i = 0; i < NUM_REQ; i++) begin : g_unit
    assign rd_tag[2*i]   = issue_src1[i];  // Even port reads operand 1
    assign rd_tag[2*i+1] = issue_src2[i];
    if (ooo_core_pkg::entry_kind(i, NUM_ALU) == ooo_isa_pkg::FU_ALU) begin : g_alu
      alu_unit u_alu (
        .clock, .reset,
        .issue_valid(issue_valid[i]), .issue_op(issue_op[i]), .issue_dest(issue_dest[i]),
        .src1_value(rd_value[2*i]), .src2_value(rd_value[2*i+1]),
        .grant(grant[i]), .req(req[i]), .res_tag(res_tag[i]),
        .res_value(res_value[i]), .busy(unit_busy[i])
      );
    end else begin : g_mult
      mult_unit #(.MULT_STAGES(MULT_STAGES)) u_mult (
        .clock, .reset,
        .issue_valid(issue_valid[i]), .issue_op(issue_op[i]), .issue_dest(issue_dest[i]),
        .src1_value(rd_value[2*i]), .src2_value(rd_value[2*i+1]),
        .grant(grant[i]), .req(req[i]), .res_tag(res_tag[i]),
        .res_value(res_value[i]), .busy(unit_busy[i])
      );
    end
  end

  cdb_arbiter #(.NUM_REQ(NUM_REQ)) u_arb (
    .clock, .reset, .req, .res_tag, .res_value,
    .grant, .cdb_valid, .cdb_tag, .cdb_value
  );

  tag_value_file #(.NUM_RD(NUM_RD)) u_tvf (
    .clock, .preload_en, .preload_tag, .preload_value,
    .cdb_valid, .cdb_tag, .cdb_value, .rd_tag, .rd_value
  );

endmodule

// File: logic/tag_value_file.sv
`timescale 1ns/1ps

module tag_value_file #(
  parameter int NUM_RD = 6
) (
  input  logic                                              clock,
  input  logic                                              preload_en,
  input  logic [ooo_isa_pkg::tag_width-1:0]                 preload_tag,
  input  logic [ooo_isa_pkg::value_width-1:0]               preload_value,
  input  logic                                              cdb_valid,
  input  logic [ooo_isa_pkg::tag_width-1:0]                 cdb_tag,
  input  logic [ooo_isa_pkg::value_width-1:0]               cdb_value,
  input  logic [NUM_RD-1:0][ooo_isa_pkg::tag_width-1:0]     rd_tag,
  output logic [NUM_RD-1:0][ooo_isa_pkg::value_width-1:0]   rd_value
);

  logic [ooo_isa_pkg::value_width-1:0] mem [2**ooo_isa_pkg::tag_width];  // One value per tag

  always_ff @(posedge clock) begin
    if (preload_en) begin
      mem[preload_tag] <= preload_value;
    end
    if (cdb_valid) begin
      mem[cdb_tag] <= cdb_value;  // Later assignment wins on the same tag
    end
  end

  // Bypass the broadcast so a same-cycle issue sees it
  always_comb begin
    for (int p = 0; p < NUM_RD; p++) begin
      if (cdb_valid && (rd_tag[p] == cdb_tag)) begin
        rd_value[p] = cdb_value;
      end else begin
        rd_value[p] = mem[rd_tag[p]];
      end
    end
  end

endmodule

// File: rs/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
  parameter int NUM_ALU = 2
) (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          en,
  input  logic                                          dispatch_en,
  input  ooo_isa_pkg::fu_kind_e                         dispatch_kind,
  input  ooo_isa_pkg::op_e                              dispatch_op,
  input  logic [ooo_isa_pkg::tag_width-1:0]             dest_tag,
  input  logic [ooo_isa_pkg::tag_width-1:0]             src1_tag,
  input  logic                                          src1_ready,
  input  logic [ooo_isa_pkg::tag_width-1:0]             src2_tag,
  input  logic                                          src2_ready,
  input  logic                                          cdb_valid,
  input  logic [ooo_isa_pkg::tag_width-1:0]             cdb_tag,
  input  logic [NUM_ALU:0]                              unit_busy,
  output logic                                          rs_hazard,
  output logic [NUM_ALU:0]                              issue_valid,
  output ooo_isa_pkg::op_e [NUM_ALU:0]                  issue_op,
  output logic [NUM_ALU:0][ooo_isa_pkg::tag_width-1:0]  issue_dest,
  output logic [NUM_ALU:0][ooo_isa_pkg::tag_width-1:0]  issue_src1,
  output logic [NUM_ALU:0][ooo_isa_pkg::tag_width-1:0]  issue_src2
);

  localparam int NUM_ENTRIES = NUM_ALU + 1;  // One entry per unit

  ooo_core_pkg::rs_entry_t [NUM_ENTRIES-1:0] entries;       // Registered entries
  ooo_core_pkg::rs_entry_t [NUM_ENTRIES-1:0] entries_next;  // Next state

  logic [NUM_ENTRIES-1:0] src1_match;   // CDB hits first operand
  logic [NUM_ENTRIES-1:0] src2_match;   // CDB hits second operand
  logic [NUM_ENTRIES-1:0] entry_ready;  // Issues this cycle
  logic [NUM_ENTRIES-1:0] entry_free;   // Can take a dispatch
  logic [NUM_ENTRIES-1:0] kind_match;   // Entry unit matches dispatch class
  logic                   accept;       // Dispatch is taken
  logic                   placed;       // Dispatch already written
  logic                   disp1_ready;  // Dispatched operand 1 ready or on CDB
  logic                   disp2_ready;  // Dispatched operand 2 ready or on CDB

  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      src1_match[i]  = entries[i].busy && cdb_valid && (entries[i].src1_tag == cdb_tag);
      src2_match[i]  = entries[i].busy && cdb_valid && (entries[i].src2_tag == cdb_tag);
      entry_ready[i] = entries[i].busy
                     && (entries[i].src1_ready || src1_match[i])
                     && (entries[i].src2_ready || src2_match[i])
                     && !unit_busy[i];                         // Unit must accept it
      entry_free[i]  = !entries[i].busy || entry_ready[i];     // Leaving counts as free
      kind_match[i]  = ooo_core_pkg::entry_kind(i, NUM_ALU) == dispatch_kind;
    end
  end

  assign rs_hazard   = ~|(entry_free & kind_match);  // No slot for this class
  assign accept      = en && dispatch_en && !rs_hazard;
  assign disp1_ready = src1_ready || (cdb_valid && (src1_tag == cdb_tag));  // Catch same-cycle result
  assign disp2_ready = src2_ready || (cdb_valid && (src2_tag == cdb_tag));

  // Issue straight from registered entries
  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      issue_valid[i] = entry_ready[i] && en;  // Frozen station does not issue
      issue_op[i]    = entries[i].op;
      issue_dest[i]  = entries[i].dest_tag;
      issue_src1[i]  = entries[i].src1_tag;
      issue_src2[i]  = entries[i].src2_tag;
    end
  end

  always_comb begin
    entries_next = entries;
    placed       = 1'b0;
    // Wakeup, each operand on its own match
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (src1_match[i]) begin
        entries_next[i].src1_ready = 1'b1;
      end
      if (src2_match[i]) begin
        entries_next[i].src2_ready = 1'b1;
      end
    end
    // Clear what issues
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (entry_ready[i]) begin
        entries_next[i] = ooo_core_pkg::rs_entry_reset;
      end
    end
    // Dispatch into lowest matching free slot
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (accept && !placed && entry_free[i] && kind_match[i]) begin
        entries_next[i].busy       = 1'b1;
        entries_next[i].op         = dispatch_op;
        entries_next[i].dest_tag   = dest_tag;
        entries_next[i].src1_tag   = src1_tag;
        entries_next[i].src1_ready = disp1_ready;
        entries_next[i].src2_tag   = src2_tag;
        entries_next[i].src2_ready = disp2_ready;
        placed                     = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        entries[i] <= ooo_core_pkg::rs_entry_reset;
      end
    end else if (en) begin
      entries <= entries_next;  // Hold everything while en is low
    end
  end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module tb_ooo_exec_core \
  -f sources.f -o tb_ooo_exec_core \
  && ./obj_dir/tb_ooo_exec_core > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "TEST RESULT: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// File: sim/tb_ooo_exec_core.sv
`timescale 1ns/1ps

module tb_ooo_exec_core;

  localparam int tw          = ooo_isa_pkg::tag_width;
  localparam int vw          = ooo_isa_pkg::value_width;
  localparam int num_tags    = 2 ** tw;
  localparam int num_instr   = 26;                    // Dispatch attempts including drops
  localparam int cycle_limit = 40 * num_instr + 100;

  logic                  clock = 1'b0;
  logic                  reset;
  logic                  en;
  logic                  dispatch_en;
  ooo_isa_pkg::fu_kind_e dispatch_kind;
  ooo_isa_pkg::op_e      dispatch_op;
  logic [tw-1:0]         dest_tag;
  logic [tw-1:0]         src1_tag;
  logic                  src1_ready;
  logic [tw-1:0]         src2_tag;
  logic                  src2_ready;
  logic                  preload_en;
  logic [tw-1:0]         preload_tag;
  logic [vw-1:0]         preload_value;
  logic                  rs_hazard;
  logic                  cdb_valid;
  logic [tw-1:0]         cdb_tag;
  logic [vw-1:0]         cdb_value;

  logic [vw-1:0] exp_val [num_tags];      // Model value per tag
  bit            accepted [num_tags];     // Tag ever taken by the station
  int            base_count [num_tags];   // Broadcasts seen before last dispatch
  int            bcast_count [num_tags];  // Broadcasts seen per tag
  bit            wait1 [num_tags];        // Operand 1 waited on a producer
  bit            wait2 [num_tags];
  logic [tw-1:0] src1_of [num_tags];      // Producer tags per consumer
  logic [tw-1:0] src2_of [num_tags];
  logic [31:0]   lfsr_state = 32'h86ee;
  int            cycle_count = 0;
  int            value_errors = 0;
  int            tag_errors = 0;
  int            order_errors = 0;
  int            missing_errors = 0;
  int            other_errors = 0;

  ooo_exec_core #(.NUM_ALU(2), .MULT_STAGES(3)) uut (
    .clock, .reset, .en, .dispatch_en, .dispatch_kind, .dispatch_op,
    .dest_tag, .src1_tag, .src1_ready, .src2_tag, .src2_ready,
    .preload_en, .preload_tag, .preload_value,
    .rs_hazard, .cdb_valid, .cdb_tag, .cdb_value
  );

  always #50 clock = ~clock;  // 100 ns period

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: no finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // Every broadcast must carry the model's value
  value_check: assert property (@(negedge clock) disable iff (reset)
    cdb_valid |-> (cdb_value == exp_val[cdb_tag]))
    else begin
      value_errors++;
      $display("[ERROR] cdb_value tag %h expected %h actual %h", cdb_tag, exp_val[cdb_tag],
               cdb_value);
    end

  // Bus monitor at mid-cycle where the bus is stable
  always @(negedge clock) begin
    if (!reset && cdb_valid) begin
      assert (accepted[cdb_tag] && bcast_count[cdb_tag] == base_count[cdb_tag]) else begin
        tag_errors++;
        $display("Tag %0d was broadcast with no accepted instruction waiting for it", cdb_tag);
      end
      assert (!wait1[cdb_tag] || bcast_count[src1_of[cdb_tag]] > base_count[src1_of[cdb_tag]])
      else begin
        order_errors++;
        $display("Tag %0d was broadcast before its first producer", cdb_tag);
      end
      assert (!wait2[cdb_tag] || bcast_count[src2_of[cdb_tag]] > base_count[src2_of[cdb_tag]])
      else begin
        order_errors++;
        $display("Tag %0d was broadcast before its second producer", cdb_tag);
      end
      bcast_count[cdb_tag]++;
    end
  end

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] next_random_bits(input int count);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int b = 0; b < count; b++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  function automatic ooo_isa_pkg::op_e random_alu_op();
    logic [2:0] code;
    code = 3'(next_random_bits(3) % 32'd5);  // ADD through XOR
    return ooo_isa_pkg::op_e'(code);
  endfunction

  // Expected result per opcode
  function automatic logic [vw-1:0] expected_result(input ooo_isa_pkg::op_e op,
                                                   input logic [vw-1:0] a,
                                                   input logic [vw-1:0] b);
    logic [2*vw-1:0] wide;
    logic [vw-1:0]   res;
    wide = a * b;
    case (op)
      ooo_isa_pkg::OP_ADD: res = a + b;
      ooo_isa_pkg::OP_SUB: res = a - b;
      ooo_isa_pkg::OP_AND: res = a & b;
      ooo_isa_pkg::OP_OR:  res = a | b;
      ooo_isa_pkg::OP_XOR: res = a ^ b;
      default:             res = wide[vw-1:0];  // Low half of product
    endcase
    return res;
  endfunction

  function automatic bit in_flight(input logic [tw-1:0] tag);
    return accepted[tag] && (bcast_count[tag] == base_count[tag]);
  endfunction

  function automatic bit any_in_flight();
    bit busy;
    busy = 1'b0;
    for (int t = 0; t < num_tags; t++) begin
      busy = busy | in_flight(tw'(t));
    end
    return busy;
  endfunction

  task automatic write_preload(input logic [tw-1:0] tag, input logic [vw-1:0] value);
    @(posedge clock);
    dispatch_en   <= 1'b0;
    preload_en    <= 1'b1;
    preload_tag   <= tag;
    preload_value <= value;
    exp_val[tag]   = value;
  endtask

  // Present until the station takes it and then record in the model
  task automatic dispatch_instr(input ooo_isa_pkg::fu_kind_e kind, input ooo_isa_pkg::op_e op,
                                input logic [tw-1:0] dest, input logic [tw-1:0] s1,
                                input logic [tw-1:0] s2);
    bit taken;
    bit r1;
    bit r2;
    taken = 1'b0;
    r1    = 1'b0;
    r2    = 1'b0;
    while (!taken) begin
      @(posedge clock);
      r1             = !in_flight(s1);  // Producer still out means not ready
      r2             = !in_flight(s2);
      en            <= 1'b1;
      preload_en    <= 1'b0;
      dispatch_en   <= 1'b1;
      dispatch_kind <= kind;
      dispatch_op   <= op;
      dest_tag      <= dest;
      src1_tag      <= s1;
      src1_ready    <= r1;
      src2_tag      <= s2;
      src2_ready    <= r2;
      @(negedge clock);
      taken = !rs_hazard;  // Hazard drops it and the loop retries
    end
    exp_val[dest]    = expected_result(op, exp_val[s1], exp_val[s2]);
    accepted[dest]   = 1'b1;
    base_count[dest] = bcast_count[dest];
    wait1[dest]      = !r1;
    wait2[dest]      = !r2;
    src1_of[dest]    = s1;
    src2_of[dest]    = s2;
  endtask

  task automatic dispatch_alu(input logic [tw-1:0] dest, input logic [tw-1:0] s1,
                              input logic [tw-1:0] s2);
    dispatch_instr(ooo_isa_pkg::FU_ALU, random_alu_op(), dest, s1, s2);
  endtask

  task automatic dispatch_mult(input logic [tw-1:0] dest, input logic [tw-1:0] s1,
                               input logic [tw-1:0] s2);
    dispatch_instr(ooo_isa_pkg::FU_MULT, ooo_isa_pkg::OP_MUL, dest, s1, s2);
  endtask

  // One ALU dispatch the station must drop
  task automatic dispatch_dropped(input logic [tw-1:0] dest, input logic en_value);
    @(posedge clock);
    en            <= en_value;
    preload_en    <= 1'b0;
    dispatch_en   <= 1'b1;
    dispatch_kind <= ooo_isa_pkg::FU_ALU;
    dispatch_op   <= ooo_isa_pkg::OP_ADD;
    dest_tag      <= dest;
    src1_tag      <= 5'd1;
    src1_ready    <= 1'b1;
    src2_tag      <= 5'd2;
    src2_ready    <= 1'b1;
    @(negedge clock);
    if (en_value) begin  // Full class must show the hazard
      assert (rs_hazard) else begin
        other_errors++;
        $display("[ERROR] rs_hazard expected %h actual %h", 1'b1, rs_hazard);
      end
    end
  endtask

  task automatic wait_drain();
    @(posedge clock);
    en          <= 1'b1;
    dispatch_en <= 1'b0;
    preload_en  <= 1'b0;
    while (any_in_flight()) begin
      @(posedge clock);
    end
  endtask

  initial begin
    reset         = 1'b1;
    en            = 1'b1;
    dispatch_en   = 1'b0;
    dispatch_kind = ooo_isa_pkg::FU_ALU;
    dispatch_op   = ooo_isa_pkg::OP_ADD;
    dest_tag      = '0;
    src1_tag      = '0;
    src1_ready    = 1'b0;
    src2_tag      = '0;
    src2_ready    = 1'b0;
    preload_en    = 1'b0;
    preload_tag   = '0;
    preload_value = '0;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    repeat (5) begin  // Quiet bus after reset
      @(negedge clock);
      assert (cdb_valid == 1'b0) else begin
        other_errors++;
        $display("[ERROR] cdb_valid expected %h actual %h", 1'b0, cdb_valid);
      end
      assert (rs_hazard == 1'b0) else begin
        other_errors++;
        $display("[ERROR] rs_hazard expected %h actual %h", 1'b0, rs_hazard);
      end
    end
    for (int t = 1; t <= 6; t++) begin
      write_preload(tw'(t), vw'(next_random_bits(vw)));
    end
    dispatch_alu(5'd8, 5'd1, 5'd2);  // Independent ops
    dispatch_alu(5'd9, 5'd3, 5'd4);
    dispatch_mult(5'd10, 5'd5, 5'd6);
    dispatch_mult(5'd11, 5'd1, 5'd6);
    dispatch_alu(5'd12, 5'd2, 5'd5);
    wait_drain();
    dispatch_mult(5'd13, 5'd1, 5'd2);  // Chain through both unit kinds
    dispatch_alu(5'd14, 5'd13, 5'd3);
    dispatch_mult(5'd15, 5'd14, 5'd13);
    dispatch_alu(5'd16, 5'd15, 5'd14);
    wait_drain();
    dispatch_mult(5'd17, 5'd3, 5'd4);  // Burst with multiplies piling up in the pipe
    dispatch_mult(5'd18, 5'd5, 5'd1);
    dispatch_mult(5'd19, 5'd2, 5'd6);
    dispatch_alu(5'd20, 5'd1, 5'd3);
    dispatch_alu(5'd21, 5'd4, 5'd5);
    dispatch_alu(5'd22, 5'd6, 5'd2);
    dispatch_alu(5'd23, 5'd3, 5'd6);
    dispatch_alu(5'd24, 5'd17, 5'd18);
    dispatch_mult(5'd25, 5'd19, 5'd20);
    wait_drain();
    dispatch_dropped(5'd30, 1'b0);  // Frozen station
    dispatch_mult(5'd26, 5'd1, 5'd2);
    dispatch_mult(5'd27, 5'd26, 5'd3);
    dispatch_alu(5'd28, 5'd27, 5'd4);  // Both ALU entries now wait
    dispatch_alu(5'd29, 5'd5, 5'd27);
    dispatch_dropped(5'd31, 1'b1);  // ALU class full
    wait_drain();
    write_preload(5'd8, vw'(next_random_bits(vw)));  // Overwrite a broadcast tag
    dispatch_alu(5'd12, 5'd8, 5'd1);
    dispatch_mult(5'd9, 5'd8, 5'd10);
    wait_drain();
    repeat (5) @(posedge clock);  // Room for stray broadcasts
    for (int t = 0; t < num_tags; t++) begin
      if (accepted[t]) begin
        assert (bcast_count[t] == base_count[t] + 1) else begin
          missing_errors++;
          $display("Tag %0d was broadcast %0d times, expected once", t,
                   bcast_count[t] - base_count[t]);
        end
      end
    end
    $display("Errors: value %0d, tag %0d, order %0d, missing %0d, other %0d",
             value_errors, tag_errors, order_errors, missing_errors, other_errors);
    if (value_errors + tag_errors + order_errors + missing_errors + other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: sources.f
common/ooo_isa_pkg.sv
common/ooo_core_pkg.sv
rs/reservation_station.sv
logic/alu_unit.sv
logic/mult_unit.sv
logic/cdb_arbiter.sv
logic/tag_value_file.sv
logic/ooo_exec_core.sv
sim/tb_ooo_exec_core.sv
